//--- Bender.yml
package:
  name: ps2_kbd

sources:
  - files:
      - hdl/ps2_frame_pkg.sv
      - hdl/ps2_apb_pkg.sv
      - hdl/ps2_sample_tick.sv
      - hdl/ps2_rx_deframer.sv
      - hdl/scan_fifo.sv
      - hdl/ps2_apb_regs.sv
      - hdl/ps2_kbd_top.sv
  - target: test
    files:
      - test/ps2_kbd_tb.sv

//--- hdl/ps2_apb_pkg.sv
// apb bus widths, register offsets, status bit positions and control bit positions
package ps2_apb_pkg;

	// -------------------------------------------------------------------------
	// bus widths
	// -------------------------------------------------------------------------

	localparam int unsigned apb_addr_w = 12;
	localparam int unsigned apb_data_w = 32;

	// -------------------------------------------------------------------------
	// register map
	// -------------------------------------------------------------------------

	// data pops the fifo head on read, status and control sit behind it
	localparam logic [apb_addr_w-1:0] reg_data = 12'h000;
	localparam logic [apb_addr_w-1:0] reg_status = 12'h004;
	localparam logic [apb_addr_w-1:0] reg_ctrl = 12'h008;

	// status bits, overflow and frame error are sticky and cleared by writing one
	localparam int unsigned st_empty = 0;
	localparam int unsigned st_full = 1;
	localparam int unsigned st_overflow = 2;
	localparam int unsigned st_frame_err = 3;
	// the fifo level field starts here and is as wide as the level port
	localparam int unsigned st_level = 8;

	// control bits
	localparam int unsigned ctrl_irq_en = 0;

endpackage

//--- hdl/ps2_apb_regs.sv
// apb slave with data, status and control registers and the keyboard interrupt
`timescale 1ns/10ps

module ps2_apb_regs import ps2_frame_pkg::*, ps2_apb_pkg::*; #(
	parameter int unsigned fifo_depth = 8
) (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [apb_addr_w-1:0] paddr,
	input  logic [apb_data_w-1:0] pwdata,
	output logic [apb_data_w-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input  scan_code_t fifo_data,
	input  logic fifo_empty,
	input  logic fifo_full,
	input  logic fifo_overflow,
	input  logic [$clog2(fifo_depth):0] fifo_level,
	output logic fifo_pop,
	input  logic frame_valid,
	input  rx_err_t frame_err,
	output logic irq
);

	localparam int unsigned lvl_w = $clog2(fifo_depth) + 1;

	// -------------------------------------------------------------------------
	// decode
	// -------------------------------------------------------------------------

	logic access;
	logic rd_access;
	logic wr_access;
	logic sel_data;
	logic sel_status;
	logic sel_ctrl;

	// every transfer completes in its access phase, there are no wait states
	assign access = psel && penable;
	assign rd_access = access && !pwrite;
	assign wr_access = access && pwrite;
	assign sel_data = (paddr == reg_data);
	assign sel_status = (paddr == reg_status);
	assign sel_ctrl = (paddr == reg_ctrl);

	assign pready = 1'b1;
	assign pslverr = access && !(sel_data || sel_status || sel_ctrl);

	// reading data takes the head out of the fifo in the same cycle
	assign fifo_pop = rd_access && sel_data && !fifo_empty;

	// -------------------------------------------------------------------------
	// flags and control
	// -------------------------------------------------------------------------

	logic irq_en;
	logic overflow_flag;
	logic frame_err_flag;

	// a new event wins over a clear that lands in the same cycle
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			irq_en <= 1'b0;
			overflow_flag <= 1'b0;
			frame_err_flag <= 1'b0;
			irq <= 1'b0;
		end else begin
			if (wr_access && sel_ctrl)
				irq_en <= pwdata[ctrl_irq_en];
			if (fifo_overflow)
				overflow_flag <= 1'b1;
			else if (wr_access && sel_status && pwdata[st_overflow])
				overflow_flag <= 1'b0;
			if (frame_valid && frame_err != err_none)
				frame_err_flag <= 1'b1;
			else if (wr_access && sel_status && pwdata[st_frame_err])
				frame_err_flag <= 1'b0;
			// level interrupt, one cycle behind the fifo state
			irq <= irq_en && !fifo_empty;
		end
	end

	// -------------------------------------------------------------------------
	// read mux
	// -------------------------------------------------------------------------

	logic [apb_data_w-1:0] status_word;

	always_comb begin
		status_word = '0;
		status_word[st_empty] = fifo_empty;
		status_word[st_full] = fifo_full;
		status_word[st_overflow] = overflow_flag;
		status_word[st_frame_err] = frame_err_flag;
		status_word[st_level +: lvl_w] = fifo_level;
	end

	// an empty fifo reads back as zero rather than a stale entry
	always_comb begin
		prdata = '0;
		if (rd_access) begin
			if (sel_data && !fifo_empty)
				prdata = apb_data_w'(fifo_data);
			else if (sel_status)
				prdata = status_word;
			else if (sel_ctrl)
				prdata[ctrl_irq_en] = irq_en;
		end
	end

	// an error response is only legal in an access phase that followed a setup phase
	a_slverr_access: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pslverr |-> penable && $past(psel && !penable))
		else $error("pslverr raised outside an apb access phase");

endmodule

//--- hdl/ps2_frame_pkg.sv
// frame length, frame bit positions, scan code type and receive error codes
package ps2_frame_pkg;

	// -------------------------------------------------------------------------
	// frame layout
	// -------------------------------------------------------------------------

	// a keyboard frame is one start bit, eight data bits, odd parity and one stop bit
	localparam int unsigned frame_bits = 11;

	// positions inside the assembled frame word, the start bit arrives first
	localparam int unsigned start_pos = 0;
	localparam int unsigned data_lsb = 1;
	localparam int unsigned parity_pos = 9;
	localparam int unsigned stop_pos = 10;

	// one received data byte as sent by the keyboard
	typedef logic [7:0] scan_code_t;

	// -------------------------------------------------------------------------
	// receive errors
	// -------------------------------------------------------------------------

	// reported with each completed frame, checked in the order listed
	typedef enum logic [1:0] {
		err_none = 2'd0,
		err_start = 2'd1,
		err_parity = 2'd2,
		err_stop = 2'd3
	} rx_err_t;

endpackage

//--- hdl/ps2_kbd_top.sv
// ps2 keyboard receiver top with sample tick, deframer, scan fifo and apb registers
`timescale 1ns/10ps

module ps2_kbd_top import ps2_frame_pkg::*, ps2_apb_pkg::*; #(
	parameter int unsigned clk_freq = 100000000,
	parameter int unsigned sample_rate = 204800,
	parameter int unsigned fifo_depth = 8
) (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic ps2_clk,
	input  logic ps2_data,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [apb_addr_w-1:0] paddr,
	input  logic [apb_data_w-1:0] pwdata,
	output logic [apb_data_w-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic irq
);

	logic tick;
	logic frame_valid;
	scan_code_t frame_code;
	rx_err_t frame_err;
	logic fifo_push;
	logic fifo_pop;
	scan_code_t fifo_data;
	logic fifo_empty;
	logic fifo_full;
	logic fifo_overflow;
	logic [$clog2(fifo_depth):0] fifo_level;

	ps2_sample_tick #(
		.clk_freq(clk_freq),
		.sample_rate(sample_rate)
	) u_tick (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.tick(tick)
	);

	ps2_rx_deframer u_deframer (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.tick(tick),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.frame_valid(frame_valid),
		.frame_code(frame_code),
		.frame_err(frame_err)
	);

	// only clean frames are queued, bad ones just raise the error flag
	assign fifo_push = frame_valid && (frame_err == err_none);

	scan_fifo #(
		.fifo_depth(fifo_depth)
	) u_fifo (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.push(fifo_push),
		.push_data(frame_code),
		.pop(fifo_pop),
		.pop_data(fifo_data),
		.empty(fifo_empty),
		.full(fifo_full),
		.overflow(fifo_overflow),
		.level(fifo_level)
	);

	ps2_apb_regs #(
		.fifo_depth(fifo_depth)
	) u_regs (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.fifo_data(fifo_data),
		.fifo_empty(fifo_empty),
		.fifo_full(fifo_full),
		.fifo_overflow(fifo_overflow),
		.fifo_level(fifo_level),
		.fifo_pop(fifo_pop),
		.frame_valid(frame_valid),
		.frame_err(frame_err),
		.irq(irq)
	);

endmodule

//--- hdl/ps2_rx_deframer.sv
// ps2 line synchronizers, clock level filter, bit shifter and frame checker
`timescale 1ns/10ps

module ps2_rx_deframer import ps2_frame_pkg::*; (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic tick,
	input  logic ps2_clk,
	input  logic ps2_data,
	output logic frame_valid,
	output scan_code_t frame_code,
	output rx_err_t frame_err
);

	// index of the last bit of a frame in the bit counter
	localparam logic [3:0] last_bit = 4'(frame_bits - 1);

	// -------------------------------------------------------------------------
	// synchronizers
	// -------------------------------------------------------------------------

	// both lines come straight from the connector, bit 1 is clock and bit 0 is data
	logic [1:0] line_s1;
	logic [1:0] line_s2;
	logic clk_sync;
	logic data_sync;

	// the lines idle high, so reset loads ones to avoid a false edge
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			line_s1 <= 2'b11;
			line_s2 <= 2'b11;
		end else begin
			line_s1 <= {ps2_clk, ps2_data};
			line_s2 <= line_s1;
		end
	end

	assign clk_sync = line_s2[1];
	assign data_sync = line_s2[0];

	// -------------------------------------------------------------------------
	// clock level filter
	// -------------------------------------------------------------------------

	// clk_level is the filtered clock, stable_cnt counts ticks at that level
	logic clk_level;
	logic [4:0] stable_cnt;
	logic sample;
	logic timeout;

	// the counter saturates at sixteen so a long idle period does not wrap
	// around and fake another low phase
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			clk_level <= 1'b1;
			stable_cnt <= '0;
		end else if (tick) begin
			if (clk_sync != clk_level) begin
				clk_level <= clk_sync;
				stable_cnt <= '0;
			end else if (stable_cnt != 5'd16) begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end
	end

	// data is taken once the clock has sat low for four ticks
	assign sample = tick && !clk_level && (stable_cnt == 5'd4);
	// a clock held high this long means the keyboard gave up mid frame
	assign timeout = tick && clk_level && (stable_cnt == 5'd16);

	// -------------------------------------------------------------------------
	// shifter and frame check
	// -------------------------------------------------------------------------

	logic [frame_bits-1:0] shift;
	logic [frame_bits-1:0] frame_word;
	logic [3:0] bit_cnt;

	// bits arrive lsb first, so each new bit enters at the top
	assign frame_word = {data_sync, shift[frame_bits-1:1]};

	// the shift register needs no reset since a full frame replaces every bit
	always_ff @(posedge sys_clk) begin
		if (sample)
			shift <= frame_word;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			bit_cnt <= '0;
			frame_valid <= 1'b0;
		end else begin
			frame_valid <= 1'b0;
			if (sample) begin
				if (bit_cnt == last_bit) begin
					bit_cnt <= '0;
					frame_valid <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else if (timeout) begin
				// drop whatever part of a frame was collected
				bit_cnt <= '0;
			end
		end
	end

	// code and error are captured together with the eleventh bit and are only
	// meaningful while frame_valid is high
	always_ff @(posedge sys_clk) begin
		if (sample && bit_cnt == last_bit) begin
			frame_code <= frame_word[data_lsb +: 8];
			if (frame_word[start_pos] != 1'b0)
				frame_err <= err_start;
			else if (^frame_word[parity_pos:data_lsb] != 1'b1)
				frame_err <= err_parity;
			else if (frame_word[stop_pos] != 1'b1)
				frame_err <= err_stop;
			else
				frame_err <= err_none;
		end
	end

	// the bit counter must never point past the stop bit
	a_bit_cnt_range: assert property (@(posedge sys_clk) disable iff (sys_rst)
		bit_cnt <= last_bit)
		else $error("bit count passed the end of the frame");

endmodule

//--- hdl/ps2_sample_tick.sv
// clock divider producing the one-cycle line-sampling tick
`timescale 1ns/10ps

module ps2_sample_tick #(
	parameter int unsigned clk_freq = 100000000,
	parameter int unsigned sample_rate = 204800
) (
	input  logic sys_clk,
	input  logic sys_rst,
	output logic tick
);

	// number of system clocks between two ticks
	localparam int unsigned divisor = clk_freq / sample_rate;
	localparam int unsigned cnt_w = (divisor > 2) ? $clog2(divisor) : 1;

	logic [cnt_w-1:0] count;

	// the counter runs down and reloads, so the first tick shows up divisor
	// cycles after reset is released and every divisor cycles after that
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			count <= cnt_w'(divisor - 1);
			tick <= 1'b0;
		end else begin
			tick <= (count == '0);
			if (count == '0)
				count <= cnt_w'(divisor - 1);
			else
				count <= count - 1'b1;
		end
	end

	// two ticks back to back would mean the divisor dropped below two
	a_tick_spacing: assert property (@(posedge sys_clk) disable iff (sys_rst)
		tick |=> !tick)
		else $error("sample tick divisor %0d is below two", divisor);

endmodule

//--- hdl/scan_fifo.sv
// synchronous scan code fifo with occupancy level and overflow pulse
`timescale 1ns/10ps

module scan_fifo import ps2_frame_pkg::*; #(
	parameter int unsigned fifo_depth = 8
) (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic push,
	input  scan_code_t push_data,
	input  logic pop,
	output scan_code_t pop_data,
	output logic empty,
	output logic full,
	output logic overflow,
	output logic [$clog2(fifo_depth):0] level
);

	// the depth is a power of two so the pointers wrap by themselves
	localparam int unsigned ptr_w = $clog2(fifo_depth);

	scan_code_t mem [fifo_depth];
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w:0] count;
	logic push_ok;
	logic pop_ok;

	// a push into a full fifo is discarded
	assign push_ok = push && !full;
	assign pop_ok = pop && !empty;

	always_ff @(posedge sys_clk) begin
		if (push_ok)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_ok, pop_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// the head is read straight from the array, one cycle after its push
	assign pop_data = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == (ptr_w + 1)'(fifo_depth));
	assign level = count;
	assign overflow = push && full;

	// the register block must hold back data reads while nothing is queued
	a_no_pop_empty: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pop |-> !empty)
		else $error("fifo popped while empty");

endmodule

//--- project.f
hdl/ps2_frame_pkg.sv
hdl/ps2_apb_pkg.sv
hdl/ps2_sample_tick.sv
hdl/ps2_rx_deframer.sv
hdl/scan_fifo.sv
hdl/ps2_apb_regs.sv
hdl/ps2_kbd_top.sv
test/ps2_kbd_tb.sv

//--- test/ps2_kbd_tb.sv
// testbench with keyboard line model, stimulus table, apb register accesses and checks
`timescale 1ns/10ps

module ps2_kbd_tb import ps2_frame_pkg::*, ps2_apb_pkg::*;;

	// a divisor of four keeps each keyboard bit short in simulation
	localparam int unsigned sample_rate = 204800;
	localparam int unsigned clk_freq = sample_rate * 4;
	localparam int unsigned fifo_depth = 8;
	// half a keyboard bit is ten ticks, well inside the sixteen tick idle limit
	localparam int half_cycles = 40;
	localparam int idle_cycles = 120;
	localparam int poll_limit = 400;
	localparam int irq_limit = 100;
	localparam int n_rows = 7;
	localparam logic [31:0] level_mask = 32'hf << st_level;

	logic sys_clk;
	logic sys_rst;
	logic ps2_clk;
	logic ps2_data;
	logic psel;
	logic penable;
	logic pwrite;
	logic [apb_addr_w-1:0] paddr;
	logic [apb_data_w-1:0] pwdata;
	logic [apb_data_w-1:0] prdata;
	logic pready;
	logic pslverr;
	logic irq;

	int mismatches;
	int timeouts;

	// stimulus table, one entry per test in each array
	string row_name [n_rows];
	logic [7:0] row_code [n_rows];
	logic row_bad_par [n_rows];
	logic row_bad_stop [n_rows];
	logic row_err [n_rows];

	ps2_kbd_top #(
		.clk_freq(clk_freq),
		.sample_rate(sample_rate),
		.fifo_depth(fifo_depth)
	) dut0 (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.irq(irq)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// -------------------------------------------------------------------------
	// helpers
	// -------------------------------------------------------------------------

	task automatic add_row(input int idx, input string name, input logic [7:0] code,
			input logic bad_par, input logic bad_stop, input logic err);
		row_name[idx] = name;
		row_code[idx] = code;
		row_bad_par[idx] = bad_par;
		row_bad_stop[idx] = bad_stop;
		row_err[idx] = err;
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			mismatches++;
			$display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	// the status word as the register map defines it
	function automatic logic [31:0] pack_status(input logic empty, input logic full,
			input logic ovf, input logic ferr, input int lvl);
		logic [31:0] word;
		word = 32'(lvl) << st_level;
		word[st_empty] = empty;
		word[st_full] = full;
		word[st_overflow] = ovf;
		word[st_frame_err] = ferr;
		return word;
	endfunction

	// setup phase then access phase, read data is taken mid access cycle
	task automatic read_reg(input logic [apb_addr_w-1:0] addr,
			output logic [apb_data_w-1:0] data, output logic err);
		@(negedge sys_clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge sys_clk);
		penable = 1'b1;
		#1;
		data = prdata;
		err = pslverr;
		// zero wait states, so every access phase must see pready high
		compare_value("apb_read_pready", 32'h1, 32'(pready));
		@(negedge sys_clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_reg(input logic [apb_addr_w-1:0] addr,
			input logic [apb_data_w-1:0] data, output logic err);
		@(negedge sys_clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge sys_clk);
		penable = 1'b1;
		#1;
		err = pslverr;
		compare_value("apb_write_pready", 32'h1, 32'(pready));
		@(negedge sys_clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	// keyboard model, data changes while the clock is high and the receiver
	// samples it during the low half, nbits below eleven cuts the frame short
	task automatic drive_frame(input logic [7:0] code, input logic bad_par,
			input logic bad_stop, input int nbits);
		logic [frame_bits-1:0] bits;
		bits = {~bad_stop, (~^code) ^ bad_par, code, 1'b0};
		for (int i = 0; i < nbits; i++) begin
			@(negedge sys_clk);
			ps2_data = bits[i];
			repeat (half_cycles) @(negedge sys_clk);
			ps2_clk = 1'b0;
			repeat (half_cycles) @(negedge sys_clk);
			ps2_clk = 1'b1;
		end
		@(negedge sys_clk);
		ps2_data = 1'b1;
		repeat (idle_cycles) @(negedge sys_clk);
	endtask

	// polls status until the masked bits match
	task automatic wait_status(input logic [31:0] mask, input logic [31:0] value,
			input string what);
		logic [31:0] word;
		logic err;
		int polls;
		polls = 0;
		read_reg(reg_status, word, err);
		while (((word & mask) != value) && polls < poll_limit) begin
			polls++;
			read_reg(reg_status, word, err);
		end
		if ((word & mask) != value) begin
			timeouts++;
			$display("timeout in %s: the status register never reached 0x%0h", what, value);
		end
	endtask

	task automatic wait_irq(input logic level, input string what);
		int cycles;
		cycles = 0;
		while (irq !== level && cycles < irq_limit) begin
			cycles++;
			@(negedge sys_clk);
		end
		if (irq !== level) begin
			timeouts++;
			$display("timeout in %s: the interrupt never went to %0b", what, level);
		end
	endtask

	// -------------------------------------------------------------------------
	// test sequence
	// -------------------------------------------------------------------------

	initial begin
		logic [31:0] rdata;
		logic err;
		logic irq_seen;
		logic [7:0] rand_code [fifo_depth+2];

		mismatches = 0;
		timeouts = 0;
		void'($urandom(97547));
		sys_rst = 1'b1;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;

		add_row(0, "good_1c", 8'h1c, 1'b0, 1'b0, 1'b0);
		add_row(1, "good_f0", 8'hf0, 1'b0, 1'b0, 1'b0);
		add_row(2, "good_00", 8'h00, 1'b0, 1'b0, 1'b0);
		add_row(3, "good_ff", 8'hff, 1'b0, 1'b0, 1'b0);
		add_row(4, "good_5a", 8'h5a, 1'b0, 1'b0, 1'b0);
		add_row(5, "bad_parity", 8'h33, 1'b1, 1'b0, 1'b1);
		add_row(6, "bad_stop", 8'h44, 1'b0, 1'b1, 1'b1);

		repeat (4) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;

		// good frames come back unchanged, bad ones only set the sticky flag
		for (int r = 0; r < n_rows; r++) begin
			drive_frame(row_code[r], row_bad_par[r], row_bad_stop[r], frame_bits);
			if (row_err[r]) begin
				wait_status(32'h1 << st_frame_err, 32'h1 << st_frame_err, row_name[r]);
				read_reg(reg_status, rdata, err);
				compare_value({row_name[r], "_status"}, pack_status(1, 0, 0, 1, 0), rdata);
				write_reg(reg_status, 32'h1 << st_frame_err, err);
				read_reg(reg_status, rdata, err);
				compare_value({row_name[r], "_cleared"}, pack_status(1, 0, 0, 0, 0), rdata);
			end else begin
				wait_status(level_mask, 32'h1 << st_level, row_name[r]);
				read_reg(reg_data, rdata, err);
				compare_value({row_name[r], "_data"}, 32'(row_code[r]), rdata);
				read_reg(reg_status, rdata, err);
				compare_value({row_name[r], "_status"}, pack_status(1, 0, 0, 0, 0), rdata);
			end
		end

		// overflow, two more codes than the fifo holds and no reads in between
		for (int i = 0; i < fifo_depth + 2; i++) begin
			rand_code[i] = 8'($urandom);
			drive_frame(rand_code[i], 1'b0, 1'b0, frame_bits);
			if (i < fifo_depth)
				wait_status(level_mask, 32'(i + 1) << st_level, "fifo_fill");
			else
				wait_status(32'h1 << st_overflow, 32'h1 << st_overflow, "fifo_overflow");
		end
		read_reg(reg_status, rdata, err);
		compare_value("overflow_status", pack_status(0, 1, 1, 0, fifo_depth), rdata);
		for (int i = 0; i < fifo_depth; i++) begin
			read_reg(reg_data, rdata, err);
			compare_value($sformatf("fifo_order_%0d", i), 32'(rand_code[i]), rdata);
		end
		read_reg(reg_status, rdata, err);
		compare_value("drained_status", pack_status(1, 0, 1, 0, 0), rdata);
		write_reg(reg_status, 32'h1 << st_overflow, err);
		read_reg(reg_status, rdata, err);
		compare_value("overflow_cleared", pack_status(1, 0, 0, 0, 0), rdata);

		// interrupt stays low while disabled even with codes waiting
		write_reg(reg_ctrl, 32'h0, err);
		drive_frame(8'h2c, 1'b0, 1'b0, frame_bits);
		drive_frame(8'h71, 1'b0, 1'b0, frame_bits);
		wait_status(level_mask, 32'h2 << st_level, "irq_fill");
		irq_seen = 1'b0;
		for (int i = 0; i < 20; i++) begin
			@(negedge sys_clk);
			if (irq !== 1'b0)
				irq_seen = 1'b1;
		end
		compare_value("irq_disabled", 32'h0, 32'(irq_seen));
		write_reg(reg_ctrl, 32'h1, err);
		wait_irq(1'b1, "irq_enable");
		read_reg(reg_ctrl, rdata, err);
		compare_value("ctrl_readback", 32'h1, rdata);
		read_reg(reg_data, rdata, err);
		compare_value("irq_data_0", 32'h2c, rdata);
		compare_value("irq_still_high", 32'h1, 32'(irq));
		read_reg(reg_data, rdata, err);
		compare_value("irq_data_1", 32'h71, rdata);
		wait_irq(1'b0, "irq_drain");
		write_reg(reg_ctrl, 32'h0, err);

		// unmapped offset and a data read with nothing queued
		read_reg(12'h00c, rdata, err);
		compare_value("unmapped_read_err", 32'h1, 32'(err));
		write_reg(12'h00c, 32'hffff_ffff, err);
		compare_value("unmapped_write_err", 32'h1, 32'(err));
		read_reg(reg_data, rdata, err);
		compare_value("empty_read_data", 32'h0, rdata);
		compare_value("empty_read_err", 32'h0, 32'(err));
		read_reg(reg_status, rdata, err);
		compare_value("empty_read_status", pack_status(1, 0, 0, 0, 0), rdata);

		// five bits then a long idle, the receiver must drop them and resync
		drive_frame(8'h96, 1'b0, 1'b0, 5);
		read_reg(reg_status, rdata, err);
		compare_value("partial_status", pack_status(1, 0, 0, 0, 0), rdata);
		drive_frame(8'ha5, 1'b0, 1'b0, frame_bits);
		wait_status(level_mask, 32'h1 << st_level, "partial_recover");
		read_reg(reg_data, rdata, err);
		compare_value("partial_recover_data", 32'ha5, rdata);
		read_reg(reg_status, rdata, err);
		compare_value("partial_recover_status", pack_status(1, 0, 0, 0, 0), rdata);

		$display("mismatches: %0d, timeouts: %0d", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
